// File: common/soc_periph_pkg.sv
////////////////////////////////////////////////////////////
// SoC peripheral subsystem shared definitions
// Bus widths, address map, register offsets and the
// fc event bit layout
////////////////////////////////////////////////////////////

`default_nettype none

package soc_periph_pkg;

    // APB bus
    localparam int unsigned APB_ADDR_WIDTH = 32;
    localparam int unsigned APB_DATA_WIDTH = 32;

    localparam int unsigned NGPIO = 32;

    // Slave select field inside the peripheral window
    localparam int unsigned SLV_SEL_LSB = 12;
    localparam int unsigned SLV_SEL_MSB = 15;
    localparam logic [SLV_SEL_MSB-SLV_SEL_LSB:0] SLV_GPIO  = 4'd1;
    localparam logic [SLV_SEL_MSB-SLV_SEL_LSB:0] SLV_TIMER = 4'd11;

    localparam int unsigned REG_OFFS_WIDTH = 12;

    // GPIO registers
    localparam logic [REG_OFFS_WIDTH-1:0] GPIO_DIR       = 12'h000;
    localparam logic [REG_OFFS_WIDTH-1:0] GPIO_IN        = 12'h004;
    localparam logic [REG_OFFS_WIDTH-1:0] GPIO_OUT       = 12'h008;
    localparam logic [REG_OFFS_WIDTH-1:0] GPIO_INTEN     = 12'h00C;
    localparam logic [REG_OFFS_WIDTH-1:0] GPIO_INTSTATUS = 12'h010;

    // Timer registers and configuration bits
    localparam logic [REG_OFFS_WIDTH-1:0] TIMER_CFG   = 12'h000;
    localparam logic [REG_OFFS_WIDTH-1:0] TIMER_COUNT = 12'h004;
    localparam logic [REG_OFFS_WIDTH-1:0] TIMER_CMP   = 12'h008;
    localparam int unsigned TIMER_CFG_EN  = 0;
    localparam int unsigned TIMER_CFG_REF = 1;

    // Fabric controller event vector
    localparam int unsigned FC_EVT_WIDTH  = 32;
    localparam int unsigned EVT_DMA_PE    = 8;
    localparam int unsigned EVT_DMA_IRQ   = 9;
    localparam int unsigned EVT_TIMER_LO  = 10;
    localparam int unsigned EVT_REF_EDGE  = 14;
    localparam int unsigned EVT_GPIO      = 15;

endpackage

`default_nettype wire

// File: source/apb_periph_decode.sv
////////////////////////////////////////////////////////////
// APB peripheral decoder
// Selects one slave from the address, returns its read
// data and flags accesses to unmapped windows
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_periph_decode import soc_periph_pkg::*; (
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
    input  logic [APB_DATA_WIDTH-1:0] gpio_rdata_i,
    input  logic [APB_DATA_WIDTH-1:0] timer_rdata_i,
    output logic [APB_DATA_WIDTH-1:0] prdata_o,
    output logic                      pslverr_o,
    output logic                      gpio_sel_o,
    output logic                      timer_sel_o,
    output logic                      penable_o,
    output logic                      pwrite_o,
    output logic [REG_OFFS_WIDTH-1:0] offs_o,
    output logic [APB_DATA_WIDTH-1:0] wdata_o
);

    logic [SLV_SEL_MSB-SLV_SEL_LSB:0] slv_field;
    logic                             hit_gpio;
    logic                             hit_timer;

    assign slv_field = paddr_i[SLV_SEL_MSB:SLV_SEL_LSB];
    assign hit_gpio  = (slv_field == SLV_GPIO);
    assign hit_timer = (slv_field == SLV_TIMER);

    // At most one select, since the two window codes differ
    assign gpio_sel_o  = psel_i & hit_gpio;
    assign timer_sel_o = psel_i & hit_timer;

    // Shared request fields toward the slaves
    assign penable_o = penable_i;
    assign pwrite_o  = pwrite_i;
    assign offs_o    = paddr_i[REG_OFFS_WIDTH-1:0];
    assign wdata_o   = pwdata_i;

    // Read data return, zero when nothing is selected
    always_comb begin
        prdata_o = '0;
        if (gpio_sel_o) begin
            prdata_o = gpio_rdata_i;
        end else if (timer_sel_o) begin
            prdata_o = timer_rdata_i;
        end
    end

    // Error only in the access phase of an unmapped transfer
    assign pslverr_o = psel_i & penable_i & ~(hit_gpio | hit_timer);

endmodule

`default_nettype wire

// File: gpio/apb_gpio.sv
////////////////////////////////////////////////////////////
// APB GPIO block
// Direction, output and interrupt enable registers, input
// synchronizer and rising-edge interrupt status
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_gpio import soc_periph_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      sel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [REG_OFFS_WIDTH-1:0] offs_i,
    input  logic [APB_DATA_WIDTH-1:0] wdata_i,
    input  logic [NGPIO-1:0]          gpio_i,
    output logic [APB_DATA_WIDTH-1:0] rdata_o,
    output logic [NGPIO-1:0]          gpio_o,
    output logic [NGPIO-1:0]          gpio_dir_o,
    output logic                      irq_o
);

    logic             wr_en;
    logic             rd_en;
    logic [NGPIO-1:0] dir_q;
    logic [NGPIO-1:0] out_q;
    logic [NGPIO-1:0] inten_q;
    logic [NGPIO-1:0] status_q;
    logic [NGPIO-1:0] sync1_q;
    logic [NGPIO-1:0] sync2_q;
    logic [NGPIO-1:0] prev_q;
    logic [NGPIO-1:0] rise_en;
    logic             status_clr;

    assign wr_en = sel_i & penable_i & pwrite_i;
    assign rd_en = sel_i & penable_i & ~pwrite_i;

    //////////////////////////////////////////////////////////
    // Configuration registers
    //////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dir_q   <= '0;
            out_q   <= '0;
            inten_q <= '0;
        end else if (wr_en) begin
            case (offs_i)
                GPIO_DIR:   dir_q   <= wdata_i;
                GPIO_OUT:   out_q   <= wdata_i;
                GPIO_INTEN: inten_q <= wdata_i;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////
    // Input sync and edge detection
    //////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign rise_en    = sync2_q & ~prev_q & inten_q;
    assign status_clr = rd_en & (offs_i == GPIO_INTSTATUS);

    // A new edge in the clearing cycle is kept
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            status_q <= '0;
        end else if (status_clr) begin
            status_q <= rise_en;
        end else begin
            status_q <= status_q | rise_en;
        end
    end

    always_comb begin
        case (offs_i)
            GPIO_DIR:       rdata_o = dir_q;
            GPIO_IN:        rdata_o = sync2_q;
            GPIO_OUT:       rdata_o = out_q;
            GPIO_INTEN:     rdata_o = inten_q;
            GPIO_INTSTATUS: rdata_o = status_q;
            default:        rdata_o = '0;
        endcase
    end

    assign gpio_o     = out_q;
    assign gpio_dir_o = dir_q;
    assign irq_o      = |status_q;

endmodule

`default_nettype wire

// File: timer/apb_timer_unit.sv
////////////////////////////////////////////////////////////
// APB timer unit
// 32-bit counter with compare, counting system clocks or
// reference ticks, with a one-cycle interrupt pulse
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module apb_timer_unit import soc_periph_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      sel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [REG_OFFS_WIDTH-1:0] offs_i,
    input  logic [APB_DATA_WIDTH-1:0] wdata_i,
    input  logic                      ref_tick_i,
    output logic [APB_DATA_WIDTH-1:0] rdata_o,
    output logic                      irq_o
);

    logic                      wr_en;
    logic [1:0]                cfg_q;
    logic [APB_DATA_WIDTH-1:0] count_q;
    logic [APB_DATA_WIDTH-1:0] cmp_q;
    logic                      tick;
    logic                      match;
    logic                      irq_q;

    assign wr_en = sel_i & penable_i & pwrite_i;

    // Count source is either every clock or each reference rising edge
    assign tick  = cfg_q[TIMER_CFG_EN] & (cfg_q[TIMER_CFG_REF] ? ref_tick_i : 1'b1);
    assign match = tick & (count_q == cmp_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;
            cmp_q <= '0;
        end else if (wr_en) begin
            case (offs_i)
                TIMER_CFG: cfg_q <= wdata_i[1:0];
                TIMER_CMP: cmp_q <= wdata_i;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////
    // Counter
    //////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (wr_en && offs_i == TIMER_CFG) begin
            // Restart on reconfiguration
            count_q <= '0;
        end else if (wr_en && offs_i == TIMER_COUNT) begin
            count_q <= wdata_i;
        end else if (match) begin
            count_q <= '0;
        end else if (tick) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Pulse in the cycle after the match
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= match;
        end
    end

    always_comb begin
        case (offs_i)
            TIMER_CFG:   rdata_o = {{(APB_DATA_WIDTH-2){1'b0}}, cfg_q};
            TIMER_COUNT: rdata_o = count_q;
            TIMER_CMP:   rdata_o = cmp_q;
            default:     rdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

endmodule

`default_nettype wire

// File: source/fc_event_map.sv
////////////////////////////////////////////////////////////
// Fabric controller event mapper
// Reference clock sync and edge detection, registered
// fc event vector
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fc_event_map import soc_periph_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    slow_clk_i,
    input  logic                    gpio_irq_i,
    input  logic                    timer_irq_i,
    input  logic                    dma_pe_evt_i,
    input  logic                    dma_pe_irq_i,
    output logic                    ref_tick_o,
    output logic [FC_EVT_WIDTH-1:0] fc_events_o
);

    logic                    ref_sync1_q;
    logic                    ref_sync2_q;
    logic                    ref_prev_q;
    logic                    ref_rise;
    logic                    ref_fall;
    logic [FC_EVT_WIDTH-1:0] events_d;
    logic [FC_EVT_WIDTH-1:0] events_q;

    // Two-flop sync, third flop for the edge compare
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ref_sync1_q <= 1'b0;
            ref_sync2_q <= 1'b0;
            ref_prev_q  <= 1'b0;
        end else begin
            ref_sync1_q <= slow_clk_i;
            ref_sync2_q <= ref_sync1_q;
            ref_prev_q  <= ref_sync2_q;
        end
    end

    assign ref_rise   = ref_sync2_q & ~ref_prev_q;
    assign ref_fall   = ~ref_sync2_q & ref_prev_q;
    assign ref_tick_o = ref_rise;

    // Unlisted positions stay zero
    always_comb begin
        events_d               = '0;
        events_d[EVT_DMA_PE]   = dma_pe_evt_i;
        events_d[EVT_DMA_IRQ]  = dma_pe_irq_i;
        events_d[EVT_TIMER_LO] = timer_irq_i;
        events_d[EVT_REF_EDGE] = ref_rise | ref_fall;
        events_d[EVT_GPIO]     = gpio_irq_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            events_q <= '0;
        end else begin
            events_q <= events_d;
        end
    end

    assign fc_events_o = events_q;

endmodule

`default_nettype wire

// File: source/soc_periph_top.sv
////////////////////////////////////////////////////////////
// SoC peripheral subsystem top level
// One APB slave port feeding GPIO and timer register
// blocks, plus the fc event mapper
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module soc_periph_top import soc_periph_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // APB slave port
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
    output logic [APB_DATA_WIDTH-1:0] prdata_o,
    output logic                      pslverr_o,

    // Pins
    input  logic [NGPIO-1:0]          gpio_i,
    input  logic                      slow_clk_i,
    input  logic                      dma_pe_evt_i,
    input  logic                      dma_pe_irq_i,
    output logic [NGPIO-1:0]          gpio_o,
    output logic [NGPIO-1:0]          gpio_dir_o,
    output logic [FC_EVT_WIDTH-1:0]   fc_events_o
);

    logic                      gpio_sel;
    logic                      timer_sel;
    logic                      slv_penable;
    logic                      slv_pwrite;
    logic [REG_OFFS_WIDTH-1:0] slv_offs;
    logic [APB_DATA_WIDTH-1:0] slv_wdata;
    logic [APB_DATA_WIDTH-1:0] gpio_rdata;
    logic [APB_DATA_WIDTH-1:0] timer_rdata;
    logic                      gpio_irq;
    logic                      timer_irq;
    logic                      ref_tick;

    //////////////////////////////////////////////////////////
    // Bus decoding
    //////////////////////////////////////////////////////////
    apb_periph_decode i_decode (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .prdata_o      ( prdata_o    ),
        .pslverr_o     ( pslverr_o   ),
        .gpio_sel_o    ( gpio_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .penable_o     ( slv_penable ),
        .pwrite_o      ( slv_pwrite  ),
        .offs_o        ( slv_offs    ),
        .wdata_o       ( slv_wdata   )
    );

    //////////////////////////////////////////////////////////
    // Register blocks
    //////////////////////////////////////////////////////////
    apb_gpio i_gpio (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .sel_i      ( gpio_sel    ),
        .penable_i  ( slv_penable ),
        .pwrite_i   ( slv_pwrite  ),
        .offs_i     ( slv_offs    ),
        .wdata_i    ( slv_wdata   ),
        .gpio_i     ( gpio_i      ),
        .rdata_o    ( gpio_rdata  ),
        .gpio_o     ( gpio_o      ),
        .gpio_dir_o ( gpio_dir_o  ),
        .irq_o      ( gpio_irq    )
    );

    apb_timer_unit i_timer (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .sel_i      ( timer_sel   ),
        .penable_i  ( slv_penable ),
        .pwrite_i   ( slv_pwrite  ),
        .offs_i     ( slv_offs    ),
        .wdata_i    ( slv_wdata   ),
        .ref_tick_i ( ref_tick    ),
        .rdata_o    ( timer_rdata ),
        .irq_o      ( timer_irq   )
    );

    // Event collection and reference clock edges
    fc_event_map i_event_map (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .slow_clk_i   ( slow_clk_i   ),
        .gpio_irq_i   ( gpio_irq     ),
        .timer_irq_i  ( timer_irq    ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .ref_tick_o   ( ref_tick     ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

`default_nettype wire

// File: dv/soc_periph_assert.sv
////////////////////////////////////////////////////////////
// APB decoder assertions
// Slave select exclusivity, error response and APB phase
// order, bound into the subsystem top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module soc_periph_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic psel_i,
    input logic penable_i,
    input logic gpio_sel_i,
    input logic timer_sel_i,
    input logic pslverr_i
);

    one_slave_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(gpio_sel_i && timer_sel_i))
        else $error("both slave selects high");

    // Unmapped windows select nothing
    err_without_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pslverr_i |-> !(gpio_sel_i || timer_sel_i))
        else $error("pslverr with a slave selected");

    access_after_setup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        penable_i |-> $past(psel_i))
        else $error("penable without psel in the previous cycle");

endmodule

`default_nettype wire

// File: dv/tb_soc_periph.sv
////////////////////////////////////////////////////////////
// SoC peripheral subsystem testbench
// Runs the operations of the pattern file against the DUT,
// drives APB and the pins, checks read data, pins and the
// fc event vector
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_soc_periph import soc_periph_pkg::*; ();

    localparam int unsigned CLK_PERIOD = 100;
    localparam int unsigned MAX_OPS    = 64;
    localparam int unsigned WAIT_LIMIT = 200;
    localparam logic [31:0] SEED       = 32'ha0801517;
    localparam logic [FC_EVT_WIDTH-1:0] EVT_MASK = (32'd1 << EVT_DMA_PE) |
        (32'd1 << EVT_DMA_IRQ) | (32'd1 << EVT_TIMER_LO) |
        (32'd1 << EVT_REF_EDGE) | (32'd1 << EVT_GPIO);

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pslverr;
    logic [NGPIO-1:0]          gpio_in;
    logic [NGPIO-1:0]          gpio_out;
    logic [NGPIO-1:0]          gpio_dir;
    logic                      slow_clk;
    logic                      dma_pe_evt;
    logic                      dma_pe_irq;
    logic [FC_EVT_WIDTH-1:0]   fc_events;

    // Four words per operation for op, a, b and c
    logic [31:0]               pat_mem [0:4*MAX_OPS-1];
    logic [APB_DATA_WIDTH-1:0] rand_slot [0:1];
    int                        n_ops = 0;
    int                        n_value_err = 0;
    int                        n_other_err = 0;

    always #(CLK_PERIOD/2) clk = ~clk;

    soc_periph_top uut (
        .clk_i        ( clk        ),
        .rst_ni       ( rst_n      ),
        .psel_i       ( psel       ),
        .penable_i    ( penable    ),
        .pwrite_i     ( pwrite     ),
        .paddr_i      ( paddr      ),
        .pwdata_i     ( pwdata     ),
        .prdata_o     ( prdata     ),
        .pslverr_o    ( pslverr    ),
        .gpio_i       ( gpio_in    ),
        .slow_clk_i   ( slow_clk   ),
        .dma_pe_evt_i ( dma_pe_evt ),
        .dma_pe_irq_i ( dma_pe_irq ),
        .gpio_o       ( gpio_out   ),
        .gpio_dir_o   ( gpio_dir   ),
        .fc_events_o  ( fc_events  )
    );

    bind soc_periph_top soc_periph_assert i_assert (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .psel_i      ( psel_i    ),
        .penable_i   ( penable_i ),
        .gpio_sel_i  ( gpio_sel  ),
        .timer_sel_i ( timer_sel ),
        .pslverr_i   ( pslverr_o )
    );

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_rdata(input logic [APB_DATA_WIDTH-1:0] got, input logic got_err,
                               input logic [APB_DATA_WIDTH-1:0] exp, input logic exp_err,
                               input logic cmp_data, input string what);
        if ((cmp_data && got !== exp) || got_err !== exp_err) begin
            n_value_err++;
            $display("FAIL t=%0t %s: rdata %h pslverr %b, expected %h pslverr %b",
                     $time, what, got, got_err, exp, exp_err);
        end
    endtask

    task automatic check_gpio(input logic [NGPIO-1:0] got, input logic [NGPIO-1:0] exp,
                              input string what);
        if (got !== exp) begin
            n_value_err++;
            $display("FAIL t=%0t %s: pins %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_events(input logic [FC_EVT_WIDTH-1:0] got,
                                input logic [FC_EVT_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            n_value_err++;
            $display("FAIL t=%0t %s: events %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            n_value_err++;
            $display("FAIL t=%0t %s: counted %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus and pin drivers
    ////////////////////////////////////////////////////////////
    task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [APB_DATA_WIDTH-1:0] wdata,
                              output logic [APB_DATA_WIDTH-1:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        // Response is combinational in the access cycle
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Counts clock edges until bit 10 is seen high
    task automatic wait_timer_event(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!fc_events[EVT_TIMER_LO] && cycles < WAIT_LIMIT);
        if (!fc_events[EVT_TIMER_LO]) begin
            n_other_err++;
            $display("ERROR: no timer event within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic toggle_slow_clk(input int toggles, input int exp_timer);
        int ref_pulses;
        int timer_pulses;
        ref_pulses   = 0;
        timer_pulses = 0;
        repeat (toggles) begin
            @(posedge clk);
            slow_clk <= ~slow_clk;
            repeat (6) begin
                @(negedge clk);
                if (fc_events[EVT_REF_EDGE]) ref_pulses++;
                if (fc_events[EVT_TIMER_LO]) timer_pulses++;
            end
        end
        check_count(ref_pulses, toggles, "reference edge events");
        check_count(timer_pulses, exp_timer, "timer events in reference mode");
    endtask

    task automatic run_op(input int idx);
        logic [31:0]               op;
        logic [31:0]               a;
        logic [31:0]               b;
        logic [31:0]               c;
        logic [APB_DATA_WIDTH-1:0] rdata;
        logic                      err;
        int                        cycles;
        op = pat_mem[4*idx];
        a  = pat_mem[4*idx+1];
        b  = pat_mem[4*idx+2];
        c  = pat_mem[4*idx+3];
        case (op)
            1: begin
                apb_access(1'b1, a, b, rdata, err);
                check_rdata(rdata, err, '0, c[0], c[0], $sformatf("write %h", a));
            end
            2: begin
                apb_access(1'b0, a, '0, rdata, err);
                check_rdata(rdata, err, b, c[0], 1'b1, $sformatf("read %h", a));
            end
            3: begin
                @(posedge clk);
                gpio_in <= a;
            end
            4: toggle_slow_clk(int'(a), int'(b));
            5: begin
                wait_timer_event(cycles);
                check_count(cycles, int'(a), "cycles to first timer event");
                if (b != 0) begin
                    wait_timer_event(cycles);
                    check_count(cycles, int'(b), "timer event period");
                end
            end
            6: begin
                rand_slot[c[0]] = $urandom;
                apb_access(1'b1, a, rand_slot[c[0]], rdata, err);
                check_rdata(rdata, err, '0, 1'b0, 1'b0, $sformatf("random write %h", a));
            end
            7: begin
                apb_access(1'b0, a, '0, rdata, err);
                check_rdata(rdata, err, rand_slot[c[0]], 1'b0, 1'b1, $sformatf("read %h", a));
                if (b == 1) check_gpio(gpio_dir, rand_slot[c[0]], "gpio_dir_o");
                if (b == 2) check_gpio(gpio_out, rand_slot[c[0]], "gpio_o");
            end
            8: begin
                repeat (b) @(posedge clk);
                @(negedge clk);
                check_events(fc_events, a, "event vector");
            end
            9: begin
                @(posedge clk);
                dma_pe_evt <= a[0];
                dma_pe_irq <= a[1];
                @(posedge clk);
                @(negedge clk);
                check_events(fc_events, b, "DMA events");
                @(posedge clk);
                dma_pe_evt <= 1'b0;
                dma_pe_irq <= 1'b0;
            end
            default: begin
                n_other_err++;
                $display("ERROR: unknown operation %0h in pattern %0d", op, idx);
            end
        endcase
    endtask

    // Unlisted event positions must never rise
    always @(negedge clk) begin
        if (rst_n) begin
            check_events(fc_events & ~EVT_MASK, '0, "unlisted event bits");
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int i;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        gpio_in    = '0;
        slow_clk   = 1'b0;
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        void'($urandom(SEED));
        for (i = 0; i < 4*MAX_OPS; i++) begin
            pat_mem[i] = '0;
        end
        $readmemh("dv/soc_periph_patterns.txt", pat_mem);
        i = 0;
        while (i < MAX_OPS && pat_mem[4*i] != 0) begin
            i++;
        end
        n_ops = i;
        if (n_ops == 0) begin
            n_other_err++;
            $display("ERROR: pattern file holds no operations");
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures",
                 n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized by the number of operations
    initial begin
        wait (n_ops > 0);
        #((n_ops * 40 + 16) * CLK_PERIOD);
        $display("ERROR: run timed out after %0d cycles", n_ops * 40 + 16);
        $display("errors: %0d value mismatches, %0d other failures",
                 n_value_err, n_other_err);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/soc_periph_patterns.txt
// Columns: op a b c (hex). 1 write a=addr b=data c=pslverr, 2 read a=addr b=data c=pslverr
// 3 pins a=value, 4 toggle slow clock a=count b=timer events, 5 timer a=first b=period
// 6 random write a=addr c=slot, 7 random read a=addr b=pin check c=slot
// 8 events a=expected b=wait cycles, 9 DMA a=inputs b=expected events
6 00001000 00000000 0
6 00001008 00000000 1
7 00001000 00000001 0
7 00001008 00000002 1
2 00005000 00000000 1
1 00002000 ffffffff 1
7 00001000 00000001 0
7 00001008 00000002 1
1 0000100c 00000001 0
3 00000001 00000000 0
8 00008000 00000005 0
2 00001010 00000001 0
8 00000000 00000002 0
3 00000003 00000000 0
2 00001004 00000003 0
2 00001010 00000000 0
8 00000000 00000001 0
1 0000b008 00000005 0
1 0000b000 00000001 0
5 00000007 00000006 0
1 0000b000 00000000 0
4 00000004 00000000 0
1 0000b008 00000002 0
1 0000b000 00000003 0
4 00000006 00000001 0
1 0000b000 00000000 0
2 0000b008 00000002 0
9 00000001 00000100 0
9 00000002 00000200 0
9 00000003 00000300 0
0 00000000 00000000 0

// File: project.f
common/soc_periph_pkg.sv
source/apb_periph_decode.sv
gpio/apb_gpio.sv
timer/apb_timer_unit.sv
source/fc_event_map.sv
source/soc_periph_top.sv
dv/soc_periph_assert.sv
dv/tb_soc_periph.sv

// File: Makefile
TOP := tb_soc_periph

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
